// File: Makefile
TOP = cpuCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

// File: list.f
source/isaPkg.sv
source/datapathPkg.sv
source/selectEncode.sv
source/registerFile.sv
source/aluStage.sv
source/stepSequencer.sv
source/cpuCore.sv
test/cpuCoreTb.sv

// File: source/aluStage.sv
`timescale 1ns/100ps

module aluStage (
    input  logic                              clock,
    input  logic                              rstN,
    input  datapathPkg::busSrcT               busSrc,
    input  datapathPkg::aluOpT                aluOp,
    input  logic                              yIn,
    input  logic                              zIn,
    input  logic [datapathPkg::dataWidth-1:0] regData,
    input  logic [datapathPkg::dataWidth-1:0] cSignExtended,
    output logic [datapathPkg::dataWidth-1:0] busData,
    output logic [datapathPkg::dataWidth-1:0] result
);
    import datapathPkg::*;

    logic [dataWidth-1:0] yReg;
    logic [dataWidth-1:0] zReg;
    logic [dataWidth-1:0] aluResult;

    always_comb begin
        case (busSrc)
            busReg:   busData = regData;
            busConst: busData = cSignExtended;
            busZ:     busData = zReg;
            default:  busData = '0;
        endcase
    end

    // Y is the left operand, the bus the right one
    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = yReg + busData;
            aluSub:  aluResult = yReg - busData;
            aluAnd:  aluResult = yReg & busData;
            default: aluResult = yReg | busData;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (yIn) begin
                yReg <= busData;
            end
            if (zIn) begin
                zReg <= aluResult;
            end
        end
    end

    assign result = zReg;

endmodule

// File: source/cpuCore.sv
`timescale 1ns/100ps

module cpuCore (
    input  logic                              clock,
    input  logic                              rstN,
    input  logic [isaPkg::instrWidth-1:0]     instr,
    input  logic                              instrValid,
    output logic                              busy,
    output logic                              done,
    output logic [datapathPkg::dataWidth-1:0] result
);
    import isaPkg::*;
    import datapathPkg::*;

    logic [instrWidth-1:0] irOut;
    logic                  gra;
    logic                  grb;
    logic                  grc;
    logic                  rIn;
    logic                  rOut;
    logic                  baOut;
    logic                  yIn;
    logic                  zIn;
    busSrcT                busSrc;
    aluOpT                 aluOp;
    logic [regCount-1:0]   regIn;
    logic [regCount-1:0]   regOut;
    logic [dataWidth-1:0]  cSignExtended;
    logic [dataWidth-1:0]  regData;
    logic [dataWidth-1:0]  busData;

    stepSequencer stepSeq (
        .clock      (clock),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .irOut      (irOut),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .rIn        (rIn),
        .rOut       (rOut),
        .baOut      (baOut),
        .yIn        (yIn),
        .zIn        (zIn),
        .busSrc     (busSrc),
        .aluOp      (aluOp),
        .busy       (busy),
        .done       (done)
    );

    selectEncode selEnc (
        .irOut         (irOut),
        .gra           (gra),
        .grb           (grb),
        .grc           (grc),
        .rIn           (rIn),
        .rOut          (rOut),
        .baOut         (baOut),
        .regIn         (regIn),
        .regOut        (regOut),
        .cSignExtended (cSignExtended)
    );

    // write data comes back from the bus mux in the ALU stage
    registerFile regFile (
        .clock   (clock),
        .rstN    (rstN),
        .regIn   (regIn),
        .regOut  (regOut),
        .baOut   (baOut),
        .busData (busData),
        .regData (regData)
    );

    aluStage alu (
        .clock         (clock),
        .rstN          (rstN),
        .busSrc        (busSrc),
        .aluOp         (aluOp),
        .yIn           (yIn),
        .zIn           (zIn),
        .regData       (regData),
        .cSignExtended (cSignExtended),
        .busData       (busData),
        .result        (result)
    );

endmodule

// File: source/datapathPkg.sv
package datapathPkg;

    // word width of bus, registers, Y and Z
    localparam int dataWidth = 32;

    // general purpose registers R0..R15
    localparam int regCount = 16;

    // what drives the shared bus
    typedef enum logic [1:0] {
        busReg   = 2'b00,
        busConst = 2'b01,
        busZ     = 2'b10
    } busSrcT;

    // operation applied between Y and the bus
    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluAnd = 2'b10,
        aluOr  = 2'b11
    } aluOpT;

endpackage

// File: source/isaPkg.sv
package isaPkg;

    // instruction word
    localparam int instrWidth = 32;

    // opcode field
    localparam int opWidth = 5;
    localparam int opMsb = 31;
    localparam int opLsb = 27;

    // register fields are four bits each
    localparam int regFieldWidth = 4;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;

    // constant field overlaps Rc, sign in its top bit
    localparam int cWidth = 19;
    localparam int cMsb = 18;
    localparam int cLsb = 0;
    localparam int cSignBit = 18;

    // encodings follow the wider load/store ISA this core is cut from
    typedef enum logic [opWidth-1:0] {
        opLdi  = 5'b00001,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01001,
        opOr   = 5'b01010,
        opAddi = 5'b01011,
        opAndi = 5'b01100,
        opOri  = 5'b01101
    } opcodeT;

endpackage

// File: source/registerFile.sv
`timescale 1ns/100ps

module registerFile (
    input  logic                              clock,
    input  logic                              rstN,
    input  logic [datapathPkg::regCount-1:0]  regIn,
    input  logic [datapathPkg::regCount-1:0]  regOut,
    input  logic                              baOut,
    input  logic [datapathPkg::dataWidth-1:0] busData,
    output logic [datapathPkg::dataWidth-1:0] regData
);
    import datapathPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // every register with its strobe high takes the bus
    always_ff @(posedge clock) begin
        for (int i = 0; i < regCount; i++) begin
            if (!rstN) begin
                regs[i] <= '0;
            end else if (regIn[i]) begin
                regs[i] <= busData;
            end
        end
    end

    // one-hot read, nothing selected gives zero
    always_comb begin
        regData = '0;
        for (int i = 0; i < regCount; i++) begin
            if (regOut[i]) begin
                regData = regData | regs[i];
            end
        end
        // base address read of R0 is a literal zero
        if (regOut[0] && baOut) begin
            regData = '0;
        end
    end

    readOneHot: assert property (
        @(posedge clock) disable iff (!rstN)
        $onehot0(regOut)
    ) else $error("registerFile: more than one register driving the bus");

    // base address reads happen in T3, never alongside a write-back
    noWriteOnBase: assert property (
        @(posedge clock) disable iff (!rstN)
        baOut |-> (regIn == '0)
    ) else $error("registerFile: write strobe during base address read");

endmodule

// File: source/selectEncode.sv
`timescale 1ns/100ps

module selectEncode (
    input  logic [isaPkg::instrWidth-1:0]     irOut,
    input  logic                              gra,
    input  logic                              grb,
    input  logic                              grc,
    input  logic                              rIn,
    input  logic                              rOut,
    input  logic                              baOut,
    output logic [datapathPkg::regCount-1:0]  regIn,
    output logic [datapathPkg::regCount-1:0]  regOut,
    output logic [datapathPkg::dataWidth-1:0] cSignExtended
);
    import isaPkg::*;
    import datapathPkg::*;

    logic [regFieldWidth-1:0] raField;
    logic [regFieldWidth-1:0] rbField;
    logic [regFieldWidth-1:0] rcField;
    logic [regFieldWidth-1:0] decIn;
    logic [regCount-1:0]      decoded;

    assign raField = irOut[raMsb:raLsb];
    assign rbField = irOut[rbMsb:rbLsb];
    assign rcField = irOut[rcMsb:rcLsb];

    // only the selected field reaches the decoder
    assign decIn = (raField & {regFieldWidth{gra}})
                 | (rbField & {regFieldWidth{grb}})
                 | (rcField & {regFieldWidth{grc}});

    // 4-to-16 decode
    always_comb begin
        decoded = '0;
        decoded[decIn] = 1'b1;
    end

    assign regIn  = decoded & {regCount{rIn}};
    // BAout enables the same register as Rout, the file zeroes R0 for it
    assign regOut = decoded & {regCount{rOut | baOut}};

    assign cSignExtended = {{(dataWidth - cWidth){irOut[cSignBit]}}, irOut[cMsb:cLsb]};

    // no clock here, so these are checked as the decode settles
    always_comb begin
        assert ($onehot0({gra, grb, grc}))
            else $error("selectEncode: more than one register field selected");
        assert ($onehot0(regIn))
            else $error("selectEncode: regIn not one-hot");
        assert ($onehot0(regOut))
            else $error("selectEncode: regOut not one-hot");
    end

endmodule

// File: source/stepSequencer.sv
`timescale 1ns/100ps

module stepSequencer (
    input  logic                          clock,
    input  logic                          rstN,
    input  logic [isaPkg::instrWidth-1:0] instr,
    input  logic                          instrValid,
    output logic [isaPkg::instrWidth-1:0] irOut,
    output logic                          gra,
    output logic                          grb,
    output logic                          grc,
    output logic                          rIn,
    output logic                          rOut,
    output logic                          baOut,
    output logic                          yIn,
    output logic                          zIn,
    output datapathPkg::busSrcT           busSrc,
    output datapathPkg::aluOpT            aluOp,
    output logic                          busy,
    output logic                          done
);
    import isaPkg::*;
    import datapathPkg::*;

    // T0..T2 of the full machine are fetch, so execution starts at T3
    typedef enum logic [1:0] {
        stIdle,
        stT3,
        stT4,
        stT5
    } stateT;

    stateT  state;
    opcodeT opcode;
    logic   useConst;
    logic   isLdi;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= stIdle;
            irOut <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (instrValid) begin
                        irOut <= instr;
                        state <= stT3;
                    end
                end
                stT3:    state <= stT4;
                stT4:    state <= stT5;
                default: state <= stIdle;
            endcase
        end
    end

    assign opcode = opcodeT'(irOut[opMsb:opLsb]);

    // opcode decode, unknown opcodes fall back to a register add
    always_comb begin
        aluOp = aluAdd;
        useConst = 1'b0;
        isLdi = 1'b0;
        case (opcode)
            opAdd: aluOp = aluAdd;
            opSub: aluOp = aluSub;
            opAnd: aluOp = aluAnd;
            opOr:  aluOp = aluOr;
            opAddi: begin
                aluOp = aluAdd;
                useConst = 1'b1;
            end
            opAndi: begin
                aluOp = aluAnd;
                useConst = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                useConst = 1'b1;
            end
            opLdi: begin
                aluOp = aluAdd;
                useConst = 1'b1;
                isLdi = 1'b1;
            end
            default: aluOp = aluAdd;
        endcase
    end

    // control strobes per step
    always_comb begin
        gra = 1'b0;
        grb = 1'b0;
        grc = 1'b0;
        rIn = 1'b0;
        rOut = 1'b0;
        baOut = 1'b0;
        yIn = 1'b0;
        zIn = 1'b0;
        busSrc = busReg;
        case (state)
            stT3: begin
                // Rb into Y, ldi reads R0 as zero
                grb = 1'b1;
                baOut = isLdi;
                rOut = !isLdi;
                yIn = 1'b1;
            end
            stT4: begin
                if (useConst) begin
                    busSrc = busConst;
                end else begin
                    grc = 1'b1;
                    rOut = 1'b1;
                end
                zIn = 1'b1;
            end
            stT5: begin
                // write-back of Z into Ra
                busSrc = busZ;
                gra = 1'b1;
                rIn = 1'b1;
            end
            default: begin
                busSrc = busReg;
            end
        endcase
    end

    assign busy = (state != stIdle);
    assign done = (state == stT5);

    // fixed latency from acceptance to done
    doneLatency: assert property (
        @(posedge clock) disable iff (!rstN)
        (instrValid && !busy) |-> ##3 (done && $past(state, 2) == stT3)
    ) else $error("stepSequencer: done not in the third cycle after acceptance");

    ignoreWhileBusy: assert property (
        @(posedge clock) disable iff (!rstN)
        (instrValid && busy) |=> $stable(irOut)
    ) else $error("stepSequencer: instruction register changed while busy");

endmodule

// File: test/cpuCoreTb.sv
`timescale 1ns/100ps

module cpuCoreTb;
    import isaPkg::*;

    localparam int maxWait = 12;
    // strobed one cycle after acceptance, would overwrite R10 if it got through
    localparam logic [31:0] ignoredInstr = {opLdi, 4'd10, 4'd0, 19'h7ffff};

    logic        clock;
    logic        rstN;
    logic [31:0] instr;
    logic        instrValid;
    logic        busy;
    logic        done;
    logic [31:0] result;

    // stimulus rows with the write-back value the register model expects
    logic [31:0] instrTab [$];
    logic [31:0] expTab [$];
    opcodeT      opTab [$];
    bit          strobeTwiceTab [$];

    logic [31:0] model [16];
    int          seed = 83443;
    int          errors = 0;
    int          tests = 0;
    bit          timedOut = 0;

    cpuCore u_dut (
        .clock      (clock),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] signExtend(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    // appends one instruction and updates the model with its result
    function automatic void addRow(input opcodeT op, input logic [3:0] ra,
                                   input logic [3:0] rb, input logic [3:0] rc,
                                   input logic [18:0] c, input bit twice);
        logic [31:0] bVal;
        logic [31:0] operand;
        logic [31:0] value;
        bit          immediate;
        immediate = (op == opAddi || op == opAndi || op == opOri || op == opLdi);
        // ldi takes R0 in the Rb field as a zero base
        bVal = (op == opLdi && rb == 4'd0) ? 32'd0 : model[rb];
        operand = immediate ? signExtend(c) : model[rc];
        case (op)
            opSub:         value = bVal - operand;
            opAnd, opAndi: value = bVal & operand;
            opOr, opOri:   value = bVal | operand;
            default:       value = bVal + operand;
        endcase
        model[ra] = value;
        if (immediate) begin
            instrTab.push_back({op, ra, rb, c});
        end else begin
            instrTab.push_back({op, ra, rb, rc, 15'd0});
        end
        expTab.push_back(value);
        opTab.push_back(op);
        strobeTwiceTab.push_back(twice);
    endfunction

    task automatic buildTable();
        logic [1:0] sel;
        opcodeT     op;
        for (int i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        // all registers are zero after reset
        addRow(opAdd, 4'd1, 4'd0, 4'd2, 19'd0, 0);
        addRow(opLdi, 4'd1, 4'd0, 4'd0, 19'd5, 0);
        addRow(opLdi, 4'd2, 4'd0, 4'd0, 19'h40000 | 19'($random(seed)), 0);
        for (int r = 3; r < 16; r++) begin
            addRow(opLdi, 4'(r), 4'd0, 4'd0, 19'($random(seed)), 0);
        end
        addRow(opLdi, 4'd4, 4'd3, 4'd0, 19'($random(seed)), 0);
        // R0 gets a value, ldi still sees zero but add reads it
        addRow(opLdi, 4'd0, 4'd0, 4'd0, 19'h00123, 0);
        addRow(opLdi, 4'd5, 4'd0, 4'd0, 19'd7, 0);
        addRow(opAdd, 4'd6, 4'd0, 4'd1, 19'd0, 0);
        addRow(opSub, 4'd7, 4'd7, 4'd2, 19'd0, 0);
        for (int i = 0; i < 12; i++) begin
            sel = 2'($random(seed));
            case (sel)
                2'd0:    op = opAdd;
                2'd1:    op = opSub;
                2'd2:    op = opAnd;
                default: op = opOr;
            endcase
            addRow(op, 4'($random(seed)), 4'($random(seed)), 4'($random(seed)), 19'd0, 0);
        end
        for (int i = 0; i < 9; i++) begin
            op = (i % 3 == 0) ? opAddi : (i % 3 == 1) ? opAndi : opOri;
            addRow(op, 4'($random(seed)), 4'($random(seed)), 4'd0, 19'($random(seed)), 0);
        end
        // second strobe while busy, then R10 is read back
        addRow(opLdi, 4'd9, 4'd0, 4'd0, 19'h01234, 1);
        addRow(opOr, 4'd11, 4'd10, 4'd0, 19'd0, 0);
    endtask

    task automatic runRow(input int row);
        int     waited;
        bit     bad;
        opcodeT op;
        op = opTab[row];
        bad = 0;
        waited = 0;
        while (busy && waited < maxWait) begin
            @(negedge clock);
            waited++;
        end
        if (busy) begin
            $display("row %0d: core stayed busy, the instruction could not be issued", row);
            timedOut = 1;
            return;
        end
        instr = instrTab[row];
        instrValid = 1'b1;
        waited = 0;
        // done is expected at the third falling edge after acceptance
        do begin
            @(negedge clock);
            waited++;
            instrValid = strobeTwiceTab[row] && waited == 1;
            instr = instrValid ? ignoredInstr : '0;
            // busy covers every step of the instruction
            if (!busy) begin
                bad = 1;
                $display("Error at %0t: row %0d busy low while executing", $time, row);
            end
        end while (!done && waited < maxWait);
        tests++;
        if (!done) begin
            $display("row %0d: no done pulse within %0d cycles", row, maxWait);
            timedOut = 1;
            return;
        end
        if (waited != 3) begin
            bad = 1;
            $display("Error at %0t: row %0d done after %0d cycles, expected 3",
                     $time, row, waited);
        end
        if (result !== expTab[row]) begin
            bad = 1;
            $display("Error at %0t: row %0d %s result %h, expected %h",
                     $time, row, op.name(), result, expTab[row]);
        end
        @(negedge clock);
        if (done) begin
            bad = 1;
            $display("Error at %0t: row %0d done high for more than one cycle", $time, row);
        end
        if (busy) begin
            bad = 1;
            $display("Error at %0t: row %0d busy still high after done", $time, row);
        end
        if (bad) begin
            errors++;
            $display("row %0d %s: mismatch", row, op.name());
        end else begin
            $display("row %0d %s: ok, result %h", row, op.name(), result);
        end
    endtask

    initial begin
        rstN = 1'b0;
        instr = '0;
        instrValid = 1'b0;
        buildTable();
        repeat (16) @(negedge clock);
        rstN = 1'b1;
        @(negedge clock);
        if (busy || done) begin
            errors++;
            $display("Error at %0t: busy or done high after reset", $time);
        end
        for (int row = 0; row < instrTab.size() && !timedOut; row++) begin
            runRow(row);
        end
        if (timedOut) begin
            $display("%0d tests run, %0d failed, stopped on timeout", tests, errors);
        end else begin
            $display("%0d tests run, %0d failed", tests, errors);
        end
        if (errors == 0 && !timedOut) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
